/* design/fetch_pkg.sv */
package fetch_pkg;

  // bus and datapath widths
  localparam int ADDR_W  = 32;
  localparam int INST_W  = 32;
  localparam int COUNT_W = 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INST_W-1:0]  inst_t;
  typedef logic [COUNT_W-1:0] count_t;

  // sequential fetch step, one word
  localparam addr_t INST_STEP = 32'd4;

  // configuration register byte offsets
  localparam addr_t CFG_CTRL      = 32'h0000_0000;
  localparam addr_t CFG_BOOT      = 32'h0000_0004;
  localparam addr_t CFG_DELIVERED = 32'h0000_0008;
  localparam addr_t CFG_DROPPED   = 32'h0000_000c;

  // one fetched word together with its address
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_rsp_t;

  // taken branch seen at decode
  typedef struct packed {
    logic  valid;
    addr_t delay_pc;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic  enable;
    addr_t boot_vector;
  } fetch_cfg_t;

  // single cycle event pulses for the counters
  typedef struct packed {
    logic delivered;
    logic dropped;
  } fetch_stat_t;

  typedef enum logic [0:0] {
    WB_IDLE,
    WB_WAIT
  } wb_state_t;

  typedef enum logic [1:0] {
    PC_OFF,
    PC_RUN,
    PC_HOLD_TARGET
  } pc_state_t;

endpackage

/* design/fetch_cfg_regs.sv */
`timescale 1ns/1ps

module fetch_cfg_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  fetch_pkg::addr_t       cfg_adr,
  input  logic [31:0]            cfg_dat_w,
  input  logic                   cfg_we,
  input  logic                   cfg_cyc,
  input  logic                   cfg_stb,
  output logic [31:0]            cfg_dat_r,
  output logic                   cfg_ack,
  input  fetch_pkg::fetch_stat_t stat,
  output fetch_pkg::fetch_cfg_t  cfg
);
  import fetch_pkg::*;

  fetch_cfg_t cfg_q;
  count_t     delivered_q;
  count_t     dropped_q;
  logic       access;

  // one access per strobe, ack follows a cycle later
  assign access = cfg_cyc && cfg_stb && !cfg_ack;
  assign cfg    = cfg_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg_ack     <= 1'b0;
      cfg_q       <= '0;
      delivered_q <= '0;
      dropped_q   <= '0;
    end
    else
    begin
      cfg_ack     <= access;
      delivered_q <= delivered_q + count_t'(stat.delivered);
      dropped_q   <= dropped_q + count_t'(stat.dropped);
      if (access && cfg_we)
      begin
        case (cfg_adr)
          CFG_CTRL: cfg_q.enable <= cfg_dat_w[0];
          CFG_BOOT: cfg_q.boot_vector <= cfg_dat_w;
          // clears both statistics counters
          CFG_DELIVERED:
          begin
            delivered_q <= '0;
            dropped_q   <= '0;
          end
          default: ;
        endcase
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk)
  begin
    if (access && !cfg_we)
    begin
      case (cfg_adr)
        CFG_CTRL:      cfg_dat_r <= {31'b0, cfg_q.enable};
        CFG_BOOT:      cfg_dat_r <= cfg_q.boot_vector;
        CFG_DELIVERED: cfg_dat_r <= delivered_q;
        CFG_DROPPED:   cfg_dat_r <= dropped_q;
        default:       cfg_dat_r <= '0;
      endcase
    end
  end

  a_single_ack: assert property (@(posedge clk) disable iff (reset) cfg_ack |=> !cfg_ack)
    else $error("cfg_ack held high for two cycles");

endmodule

/* design/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
  input  logic                  clk,
  input  logic                  reset,
  input  fetch_pkg::fetch_cfg_t cfg,
  input  logic                  flush,
  input  fetch_pkg::addr_t      flush_vector,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  room,
  output logic                  req_valid,
  output fetch_pkg::addr_t      req_addr,
  input  logic                  req_ready
);
  import fetch_pkg::*;

  pc_state_t state_q;
  addr_t     pc_q;
  addr_t     target_q;
  logic      xfer;

  // only ask for a word when the buffer can take it
  assign req_valid = (state_q != PC_OFF) && room;
  assign req_addr  = pc_q;
  assign xfer      = req_valid && req_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= PC_OFF;
      pc_q    <= '0;
    end
    else if (!cfg.enable)
    begin
      state_q <= PC_OFF;
    end
    else if (state_q == PC_OFF)
    begin
      state_q <= PC_RUN;
      pc_q    <= cfg.boot_vector;
    end
    else if (flush)
    begin
      state_q <= PC_RUN;
      pc_q    <= flush_vector;
    end
    else if (redirect.valid && pc_q != redirect.delay_pc)
    begin
      // delay slot already fetched or in flight
      state_q <= PC_RUN;
      pc_q    <= redirect.target;
    end
    else if (redirect.valid)
    begin
      if (xfer)
      begin
        state_q <= PC_RUN;
        pc_q    <= redirect.target;
      end
      else
        state_q <= PC_HOLD_TARGET;
    end
    else if (xfer)
    begin
      // delay slot has gone out, now take the branch
      if (state_q == PC_HOLD_TARGET)
      begin
        state_q <= PC_RUN;
        pc_q    <= target_q;
      end
      else
        pc_q <= pc_q + INST_STEP;
    end
  end

  always_ff @(posedge clk)
  begin
    if (redirect.valid)
      target_q <= redirect.target;
  end

endmodule

/* design/imem_wb_master.sv */
`timescale 1ns/1ps

module imem_wb_master (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  fetch_pkg::addr_t      req_addr,
  output logic                  req_ready,
  output fetch_pkg::addr_t      imem_adr,
  output logic                  imem_cyc,
  output logic                  imem_stb,
  input  fetch_pkg::inst_t      imem_dat,
  input  logic                  imem_ack,
  output logic                  rsp_valid,
  output fetch_pkg::fetch_rsp_t rsp
);
  import fetch_pkg::*;

  wb_state_t state_q;
  addr_t     adr_q;
  logic      xfer;

  assign req_ready = (state_q == WB_IDLE);
  assign xfer      = req_valid && req_ready;

  // cyc and stb move together in a classic cycle
  assign imem_cyc = (state_q == WB_WAIT);
  assign imem_stb = (state_q == WB_WAIT);
  assign imem_adr = adr_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q   <= WB_IDLE;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= imem_cyc && imem_ack;
      case (state_q)
        WB_IDLE: if (xfer) state_q <= WB_WAIT;
        WB_WAIT: if (imem_ack) state_q <= WB_IDLE;
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
      adr_q <= req_addr;
    if (imem_cyc && imem_ack)
    begin
      rsp.pc   <= adr_q;
      rsp.inst <= imem_dat;
    end
  end

  a_stb_hold: assert property (@(posedge clk) disable iff (reset)
    imem_stb && !imem_ack |=> imem_stb && $stable(imem_adr))
    else $error("imem strobe or address changed before ack");

endmodule

/* design/if_id_buffer.sv */
`timescale 1ns/1ps

module if_id_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rsp_valid,
  input  fetch_pkg::fetch_rsp_t  rsp,
  input  logic                   flush,
  input  fetch_pkg::addr_t       flush_vector,
  input  logic                   id_stall,
  input  logic                   branch_taken,
  input  fetch_pkg::addr_t       branch_target,
  output logic                   room,
  output fetch_pkg::redirect_t   redirect,
  output fetch_pkg::fetch_stat_t stat,
  output logic                   id_valid,
  output fetch_pkg::addr_t       id_pc,
  output fetch_pkg::inst_t       id_inst,
  output logic                   id_in_delay_slot
);
  import fetch_pkg::*;

  logic       started_q;
  addr_t      exp_q;
  logic       jump_pending_q;
  addr_t      jump_target_q;
  logic       skid_valid_q;
  logic       skid_ds_q;
  fetch_rsp_t skid_q;

  logic  consume;
  logic  out_free;
  logic  branch_ok;
  logic  ds_in_skid;
  logic  jump_cur;
  logic  accept;
  addr_t exp_cur;
  addr_t target_cur;

  assign consume  = id_valid && !id_stall;
  assign out_free = !id_valid || consume;
  // a branch sitting in a delay slot is ignored
  assign branch_ok = consume && branch_taken && !id_in_delay_slot && !flush;

  // delay slot already parked in skid, so the target is due next
  assign ds_in_skid = branch_ok && skid_valid_q;
  assign exp_cur    = ds_in_skid ? branch_target : exp_q;
  assign jump_cur   = !ds_in_skid && (branch_ok || jump_pending_q);
  assign target_cur = branch_ok ? branch_target : jump_target_q;

  assign accept = rsp_valid && !flush && (!started_q || rsp.pc == exp_cur);

  // also keep room low while a word is landing in skid
  assign room = !skid_valid_q && !(rsp_valid && id_valid && id_stall);

  assign redirect.valid    = branch_ok;
  assign redirect.delay_pc = id_pc + INST_STEP;
  assign redirect.target   = branch_target;

  assign stat.delivered = consume;
  assign stat.dropped   = rsp_valid && !accept;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      started_q        <= 1'b0;
      exp_q            <= '0;
      jump_pending_q   <= 1'b0;
      skid_valid_q     <= 1'b0;
      skid_ds_q        <= 1'b0;
      id_valid         <= 1'b0;
      id_in_delay_slot <= 1'b0;
    end
    else if (flush)
    begin
      started_q        <= 1'b1;
      exp_q            <= flush_vector;
      jump_pending_q   <= 1'b0;
      skid_valid_q     <= 1'b0;
      id_valid         <= 1'b0;
      id_in_delay_slot <= 1'b0;
    end
    else
    begin
      // expected address of the next word in program order
      if (accept)
      begin
        started_q      <= 1'b1;
        jump_pending_q <= 1'b0;
        exp_q          <= jump_cur ? target_cur : rsp.pc + INST_STEP;
      end
      else
      begin
        jump_pending_q <= jump_cur;
        exp_q          <= exp_cur;
      end

      if (out_free)
      begin
        if (skid_valid_q)
        begin
          id_valid         <= 1'b1;
          id_pc            <= skid_q.pc;
          id_inst          <= skid_q.inst;
          id_in_delay_slot <= skid_ds_q || ds_in_skid;
          skid_valid_q     <= accept;
          skid_q           <= rsp;
          skid_ds_q        <= jump_cur;
        end
        else if (accept)
        begin
          id_valid         <= 1'b1;
          id_pc            <= rsp.pc;
          id_inst          <= rsp.inst;
          id_in_delay_slot <= jump_cur;
        end
        else
        begin
          id_valid         <= 1'b0;
          id_in_delay_slot <= 1'b0;
        end
      end
      else if (accept)
      begin
        // decode stalled, park the word
        skid_valid_q <= 1'b1;
        skid_q       <= rsp;
        skid_ds_q    <= jump_cur;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    jump_target_q <= target_cur;
  end

  a_skid_free: assert property (@(posedge clk) disable iff (reset) rsp_valid |-> !skid_valid_q)
    else $error("fetch response arrived with the skid slot full");

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             reset,
  // instruction memory, wishbone master
  output fetch_pkg::addr_t imem_adr,
  output logic             imem_cyc,
  output logic             imem_stb,
  input  fetch_pkg::inst_t imem_dat,
  input  logic             imem_ack,
  // configuration, wishbone slave
  input  fetch_pkg::addr_t cfg_adr,
  input  logic [31:0]      cfg_dat_w,
  input  logic             cfg_we,
  input  logic             cfg_cyc,
  input  logic             cfg_stb,
  output logic [31:0]      cfg_dat_r,
  output logic             cfg_ack,
  // decode side
  output logic             id_valid,
  output fetch_pkg::addr_t id_pc,
  output fetch_pkg::inst_t id_inst,
  output logic             id_in_delay_slot,
  input  logic             id_stall,
  input  logic             branch_taken,
  input  fetch_pkg::addr_t branch_target,
  input  logic             flush,
  input  fetch_pkg::addr_t flush_vector
);
  import fetch_pkg::*;

  fetch_cfg_t  cfg;
  fetch_stat_t stat;
  redirect_t   redirect;
  fetch_rsp_t  rsp;
  addr_t       req_addr;
  logic        req_valid;
  logic        req_ready;
  logic        rsp_valid;
  logic        room;

  fetch_cfg_regs i_cfg_regs (
    .clk, .reset, .cfg_adr, .cfg_dat_w, .cfg_we, .cfg_cyc, .cfg_stb,
    .cfg_dat_r, .cfg_ack, .stat, .cfg
  );

  pc_gen i_pc_gen (
    .clk, .reset, .cfg, .flush, .flush_vector, .redirect, .room,
    .req_valid, .req_addr, .req_ready
  );

  imem_wb_master i_imem_wb_master (
    .clk, .reset, .req_valid, .req_addr, .req_ready,
    .imem_adr, .imem_cyc, .imem_stb, .imem_dat, .imem_ack,
    .rsp_valid, .rsp
  );

  // also the source of branch redirects and event pulses
  if_id_buffer i_if_id_buffer (
    .clk, .reset, .rsp_valid, .rsp, .flush, .flush_vector,
    .id_stall, .branch_taken, .branch_target, .room, .redirect, .stat,
    .id_valid, .id_pc, .id_inst, .id_in_delay_slot
  );

endmodule

/* verification/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker (
  input  logic             clk,
  input  logic             reset,
  input  fetch_pkg::addr_t cfg_adr,
  input  logic [31:0]      cfg_dat_w,
  input  logic             cfg_we,
  input  logic             cfg_cyc,
  input  logic             cfg_stb,
  input  logic [31:0]      cfg_dat_r,
  input  logic             cfg_ack,
  input  logic             id_valid,
  input  fetch_pkg::addr_t id_pc,
  input  fetch_pkg::inst_t id_inst,
  input  logic             id_in_delay_slot,
  input  logic             id_stall,
  input  logic             branch_taken,
  input  fetch_pkg::addr_t branch_target,
  input  logic             flush,
  input  fetch_pkg::addr_t flush_vector,
  input  logic             run_done,
  output int               checks,
  output int               errors
);
  import fetch_pkg::*;

  int         test_checks [8];
  int         test_errors [8];
  int         delivered;
  addr_t      exp_pc = '0;
  addr_t      target = '0;
  logic       exp_ds = 1'b0;
  logic [2:0] kind = 3'd1;
  logic       enable_q = 1'b0;
  addr_t      boot_q = '0;
  addr_t      rd_adr = '0;
  logic       rd_we = 1'b1;
  logic       hold_q = 1'b0;
  logic       flush_q = 1'b0;
  logic       reported = 1'b0;
  fetch_rsp_t held;
  logic       held_ds;

  // memory image is the address xored with a key and rotated left by 7
  function automatic inst_t expected_inst(input addr_t a);
    logic [31:0] x;
    x = a ^ 32'h9e37_79b9;
    return {x[24:0], x[31:25]};
  endfunction

  task automatic compare(input logic [2:0] test, input string name,
                         input logic [31:0] got, input logic [31:0] expected);
    checks++;
    test_checks[test]++;
    if (got !== expected)
    begin
      errors++;
      test_errors[test]++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic report(input logic [2:0] test);
    string name;
    case (test)
      3'd1:    name = "configuration";
      3'd2:    name = "sequential fetch";
      3'd3:    name = "back-pressure";
      3'd4:    name = "delay slot";
      3'd5:    name = "flush";
      default: name = "counters";
    endcase
    $display("test %0d %s: %0d checks, %0d errors", test, name,
             test_checks[test], test_errors[test]);
  endtask

  always @(posedge clk)
  begin
    if (!reset)
    begin
      // read data is valid while ack is high
      if (cfg_ack && !rd_we)
      begin
        case (rd_adr)
          CFG_CTRL: compare(3'd1, "cfg_dat_r", cfg_dat_r, {31'b0, enable_q});
          CFG_BOOT: compare(3'd1, "cfg_dat_r", cfg_dat_r, boot_q);
          CFG_DELIVERED:
          begin
            compare(3'd6, "cfg_dat_r", cfg_dat_r, delivered);
            report(3'd6);
          end
          default: ;
        endcase
      end
      if (cfg_cyc && cfg_stb && !cfg_ack)
      begin
        rd_adr = cfg_adr;
        rd_we  = cfg_we;
        if (cfg_we && cfg_adr == CFG_CTRL)
          enable_q = cfg_dat_w[0];
        if (cfg_we && cfg_adr == CFG_BOOT)
        begin
          boot_q = cfg_dat_w;
          exp_pc = cfg_dat_w;
        end
      end

      // decode stalled last cycle, so nothing may move
      if (hold_q)
      begin
        compare(3'd3, "id_valid", 32'(id_valid), 32'd1);
        compare(3'd3, "id_pc", id_pc, held.pc);
        compare(3'd3, "id_inst", id_inst, held.inst);
        compare(3'd3, "id_in_delay_slot", 32'(id_in_delay_slot), 32'(held_ds));
      end
      hold_q    = id_valid && id_stall && !flush;
      held.pc   = id_pc;
      held.inst = id_inst;
      held_ds   = id_in_delay_slot;
      if (flush_q)
        compare(3'd5, "id_valid", 32'(id_valid), 32'd0);
      flush_q = flush;

      if (id_valid && !id_stall)
      begin
        delivered++;
        compare(kind, "id_pc", id_pc, exp_pc);
        compare(kind, "id_inst", id_inst, expected_inst(id_pc));
        compare(kind, "id_in_delay_slot", 32'(id_in_delay_slot), 32'(exp_ds));
        if (kind == 3'd1)
          report(3'd1);
        if (branch_taken && !exp_ds && !flush)
        begin
          target = branch_target;
          exp_pc = exp_pc + 32'd4;
          exp_ds = 1'b1;
          kind   = 3'd4;
        end
        else if (exp_ds)
        begin
          // target follows the finished delay slot
          exp_pc = target;
          exp_ds = 1'b0;
          kind   = 3'd4;
        end
        else
        begin
          exp_pc = exp_pc + 32'd4;
          kind   = 3'd2;
        end
      end
      if (flush)
      begin
        exp_pc = flush_vector;
        exp_ds = 1'b0;
        kind   = 3'd5;
      end

      if (run_done && !reported)
      begin
        reported = 1'b1;
        for (int t = 2; t <= 5; t++)
          report(3'(t));
      end
    end
  end

endmodule

/* verification/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int RUN_CYCLES     = 3000;
  // margin for setup, wait states and the closing register read
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;

  logic        clk = 1'b0;
  logic        reset;
  addr_t       imem_adr;
  logic        imem_cyc;
  logic        imem_stb;
  inst_t       imem_dat = '0;
  logic        imem_ack = 1'b0;
  addr_t       cfg_adr;
  logic [31:0] cfg_dat_w;
  logic        cfg_we;
  logic        cfg_cyc;
  logic        cfg_stb;
  logic [31:0] cfg_dat_r;
  logic        cfg_ack;
  logic        id_valid;
  addr_t       id_pc;
  inst_t       id_inst;
  logic        id_in_delay_slot;
  logic        id_stall;
  logic        branch_taken;
  addr_t       branch_target;
  logic        flush;
  addr_t       flush_vector;
  logic        run_done;
  logic        in_cycle = 1'b0;
  int          waits;
  int          cycle_count;
  int          checks;
  int          errors;
  int unsigned first_draw;

  fetch_unit i_fetch_unit (.*);

  fetch_checker i_fetch_checker (.*);

  // memory image is the address xored with a key and rotated left by 7
  function automatic inst_t word_at(input addr_t a);
    logic [31:0] x;
    x = a ^ 32'h9e37_79b9;
    return {x[24:0], x[31:25]};
  endfunction

  function automatic addr_t random_addr();
    return $urandom & 32'h0000_fffc;
  endfunction

  // one classic cycle on the configuration bus, entered on a falling edge
  task automatic config_access(input addr_t adr, input logic we, input logic [31:0] data);
    cfg_adr   = adr;
    cfg_dat_w = data;
    cfg_we    = we;
    cfg_cyc   = 1'b1;
    cfg_stb   = 1'b1;
    @(negedge clk);
    while (!cfg_ack)
      @(negedge clk);
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we  = 1'b0;
    @(negedge clk);
  endtask

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // instruction memory with 0 to 3 wait states per cycle
  always @(negedge clk)
  begin
    if (imem_ack || !imem_cyc || !imem_stb)
    begin
      imem_ack = 1'b0;
      in_cycle = 1'b0;
    end
    else
    begin
      if (!in_cycle)
      begin
        in_cycle = 1'b1;
        waits    = $urandom_range(3, 0);
      end
      if (waits == 0)
      begin
        imem_ack = 1'b1;
        imem_dat = word_at(imem_adr);
      end
      else
        waits--;
    end
  end

  initial
  begin
    first_draw    = $urandom(32'h5406dfbb);
    reset         = 1'b1;
    cfg_adr       = '0;
    cfg_dat_w     = '0;
    cfg_we        = 1'b0;
    cfg_cyc       = 1'b0;
    cfg_stb       = 1'b0;
    id_stall      = 1'b1;
    branch_taken  = 1'b0;
    branch_target = '0;
    flush         = 1'b0;
    flush_vector  = '0;
    run_done      = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    config_access(CFG_BOOT, 1'b1, random_addr());
    config_access(CFG_CTRL, 1'b1, 32'd1);
    config_access(CFG_CTRL, 1'b0, '0);
    config_access(CFG_BOOT, 1'b0, '0);

    // decode waits for the boot word, then takes it
    while (!id_valid)
      @(negedge clk);
    id_stall = 1'b0;
    @(negedge clk);

    for (int n = 0; n < RUN_CYCLES; n++)
    begin
      id_stall      = ($urandom % 100) < 30;
      flush         = ($urandom % 100) < 2;
      flush_vector  = random_addr();
      branch_taken  = !flush && id_valid && !id_stall && !id_in_delay_slot
                      && ($urandom % 100) < 10;
      branch_target = random_addr();
      @(negedge clk);
    end

    id_stall     = 1'b1;
    branch_taken = 1'b0;
    flush        = 1'b0;
    run_done     = 1'b1;
    repeat (3) @(negedge clk);
    config_access(CFG_DELIVERED, 1'b0, '0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* build.f */
design/fetch_pkg.sv
design/fetch_cfg_regs.sv
design/pc_gen.sv
design/imem_wb_master.sv
design/if_id_buffer.sv
design/fetch_unit.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fetch_tb -f build.f -o fetch_sim

output=$(./obj_dir/fetch_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'NO ERRORS'; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
